// File: hw/mpu_bus_pkg.sv
`default_nettype none

package mpu_bus_pkg;

	// ========================================
	// bus geometry
	// ========================================

	localparam int ADR_W = 32;          // byte address
	localparam int DAT_W = 32;          // same width the peripherals use
	localparam int SEL_W = DAT_W / 8;   // one select per byte lane

	// ========================================
	// address map
	// ========================================

	// timer and controller are 256 byte pages, compared on bits 31 to 8
	localparam logic [ADR_W-1:0] PIT_BASE  = 32'hFFDC_1100;
	localparam logic [ADR_W-1:0] PIC_BASE  = 32'hFFDC_0F00;
	// card memory sits at the bottom, its size comes from the top level
	localparam logic [ADR_W-1:0] CARD_BASE = 32'h0000_0000;

	// decoded target of the current access
	typedef enum logic [1:0] {
		REG_NONE,   // nothing mapped here, answered with err
		REG_PIT,    // interval timer
		REG_PIC,    // interrupt controller
		REG_CARD    // scratch memory
	} region_e;

endpackage

`default_nettype wire

// File: hw/mpu_reg_pkg.sv
`default_nettype none

package mpu_reg_pkg;

	// ========================================
	// interrupt controller word offsets
	// ========================================

	typedef enum logic [2:0] {
		PIC_CAUSE  = 3'd0,   // read only, highest pending source
		PIC_ENABLE = 3'd1,   // one enable bit per source
		PIC_EDGE   = 3'd2,   // set bit latches on a rising input
		PIC_CLEAR  = 3'd3,   // write a source number to drop its latch
		PIC_LEVEL  = 3'd4    // priority presented on irq
	} pic_reg_e;

	// ========================================
	// timer channel word offsets
	// ========================================

	// channel n occupies words 4n to 4n+3, last word of each is unused
	typedef enum logic [1:0] {
		PIT_LOAD  = 2'd0,    // reload value
		PIT_COUNT = 2'd1,    // read only current count
		PIT_CTRL  = 2'd2     // bit 0 enable, bits 2:1 mode
	} pit_reg_e;

	// counting behaviour once zero is reached
	typedef enum logic [1:0] {
		PIT_ONESHOT  = 2'd0, // stop and drop enable
		PIT_PERIODIC = 2'd1  // reload and keep going
	} pit_mode_e;

endpackage

`default_nettype wire

// File: hw/mpu_pit.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_pit (
	input  wire         clk_i,
	input  wire         rst_n_i,
	input  wire         cyc_i,
	input  wire         stb_i,
	input  wire         we_i,
	input  wire  [3:0]  sel_i,
	input  wire  [3:0]  adr_i,    // word index, channel in [3:2]
	input  wire  [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic [2:0]  out_o     // one clock pulse per channel at zero
);

	logic [31:0]            load_q  [3];
	logic [31:0]            count_q [3];
	logic [2:0]             en_q;
	mpu_reg_pkg::pit_mode_e mode_q  [3];

	logic                   req;      // first clock of an access
	logic [1:0]             ch;
	logic                   ch_ok;    // channel 3 does not exist
	mpu_reg_pkg::pit_reg_e  rsel;

	assign req   = cyc_i & stb_i & ~ack_o;   // no second ack on a held strobe
	assign ch    = adr_i[3:2];
	assign ch_ok = (ch != 2'd3);
	assign rsel  = mpu_reg_pkg::pit_reg_e'(adr_i[1:0]);

	// ========================================
	// bus handshake
	// ========================================

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= req;
	end

	// ========================================
	// counters and register writes
	// ========================================

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 3; i++) begin
				load_q[i]  <= '0;
				count_q[i] <= '0;
				mode_q[i]  <= mpu_reg_pkg::PIT_ONESHOT;
			end
			en_q  <= '0;
			out_o <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				out_o[i] <= 1'b0;
				if (en_q[i]) begin
					// a count of 1 steps to zero now, 0 only after a zero load
					if (count_q[i] <= 32'd1) begin
						out_o[i] <= 1'b1;
						if (mode_q[i] == mpu_reg_pkg::PIT_PERIODIC) begin
							count_q[i] <= load_q[i];   // next period
						end else begin
							count_q[i] <= '0;          // hold at zero
							en_q[i]    <= 1'b0;
						end
					end else begin
						count_q[i] <= count_q[i] - 32'd1;
					end
				end
			end

			// bus writes come last so they win over counting
			if (req && we_i && ch_ok) begin
				case (rsel)
				mpu_reg_pkg::PIT_LOAD: begin
					for (int b = 0; b < 4; b++)
						if (sel_i[b])
							load_q[ch][8*b +: 8] <= dat_i[8*b +: 8];
				end
				mpu_reg_pkg::PIT_CTRL: begin
					if (sel_i[0]) begin
						en_q[ch]   <= dat_i[0];
						mode_q[ch] <= mpu_reg_pkg::pit_mode_e'(dat_i[2:1]);
						if (dat_i[0])
							count_q[ch] <= load_q[ch];   // start from reload value
					end
				end
				default: ;   // count is read only
				endcase
			end
		end
	end

	// read data, captured with the ack
	always_ff @(posedge clk_i) begin
		if (req) begin
			dat_o <= '0;
			if (ch_ok) begin
				case (rsel)
				mpu_reg_pkg::PIT_LOAD:  dat_o <= load_q[ch];
				mpu_reg_pkg::PIT_COUNT: dat_o <= count_q[ch];
				mpu_reg_pkg::PIT_CTRL:  dat_o <= {29'd0, mode_q[ch], en_q[ch]};
				default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/mpu_pic.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_pic (
	input  wire         clk_i,
	input  wire         rst_n_i,
	input  wire         cyc_i,
	input  wire         stb_i,
	input  wire         we_i,
	input  wire  [2:0]  adr_i,    // word offset
	input  wire  [31:0] dat_i,
	input  wire  [31:0] src_i,    // source 0 is never used
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic [2:0]  irq_o,    // programmed level while anything is pending
	output logic [6:0]  cause_o   // highest enabled pending source
);

	logic [31:0]           enable_q;
	logic [31:0]           edge_q;    // 1 latched, 0 level
	logic [31:0]           latch_q;
	logic [31:0]           src_d;     // last clock's inputs for edge detect
	logic [2:0]            level_q;

	logic                  req;
	mpu_reg_pkg::pic_reg_e rsel;
	logic [31:0]           rise;
	logic [31:0]           pending;
	logic [31:0]           active;    // pending and enabled
	logic [31:0]           clr_mask;
	logic [4:0]            top_src;

	assign req  = cyc_i & stb_i & ~ack_o;
	assign rsel = mpu_reg_pkg::pic_reg_e'(adr_i);
	assign rise = src_i & ~src_d;

	// edge sources come from the latch, level sources straight from the pin
	assign pending = (edge_q & latch_q) | (~edge_q & src_i);
	assign active  = pending & enable_q & 32'hFFFF_FFFE;

	// ========================================
	// clear decode and priority encoder
	// ========================================

	always_comb begin
		clr_mask = '0;
		if (req && we_i && rsel == mpu_reg_pkg::PIC_CLEAR)
			clr_mask[dat_i[4:0]] = 1'b1;   // one latch per write
	end

	always_comb begin
		top_src = '0;
		for (int i = 1; i < 32; i++)
			if (active[i])
				top_src = 5'(i);   // later index overrides, so highest wins
	end

	// ========================================
	// registers
	// ========================================

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o    <= 1'b0;
			enable_q <= '0;
			edge_q   <= '0;
			latch_q  <= '0;
			src_d    <= '0;
			level_q  <= '0;
			irq_o    <= '0;
			cause_o  <= '0;
		end else begin
			ack_o <= req;
			src_d <= src_i;
			// a new rise beats a clear in the same clock
			latch_q <= ((latch_q & ~clr_mask) | rise) & edge_q;
			irq_o   <= (|active) ? level_q : 3'd0;
			cause_o <= {2'd0, top_src};
			if (req && we_i) begin
				case (rsel)
				mpu_reg_pkg::PIC_ENABLE: enable_q <= dat_i;
				mpu_reg_pkg::PIC_EDGE:   edge_q   <= dat_i;
				mpu_reg_pkg::PIC_LEVEL:  level_q  <= dat_i[2:0];
				default: ;   // cause is read only, clear handled above
				endcase
			end
		end
	end

	// read data
	always_ff @(posedge clk_i) begin
		if (req) begin
			case (rsel)
			mpu_reg_pkg::PIC_CAUSE:  dat_o <= {25'd0, cause_o};
			mpu_reg_pkg::PIC_ENABLE: dat_o <= enable_q;
			mpu_reg_pkg::PIC_EDGE:   dat_o <= edge_q;
			mpu_reg_pkg::PIC_CLEAR:  dat_o <= latch_q;   // latched sources
			mpu_reg_pkg::PIC_LEVEL:  dat_o <= {29'd0, level_q};
			default:                 dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/mpu_card_mem.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_card_mem #(
	parameter  int CARD_WORDS = 512,            // power of two
	localparam int AW         = $clog2(CARD_WORDS)
) (
	input  wire                              clk_i,
	input  wire                              rst_n_i,
	input  wire                              cyc_i,
	input  wire                              stb_i,
	input  wire                              we_i,
	input  wire  [mpu_bus_pkg::SEL_W-1:0]    sel_i,
	input  wire  [AW-1:0]                    adr_i,    // word index
	input  wire  [mpu_bus_pkg::DAT_W-1:0]    dat_i,
	output logic [mpu_bus_pkg::DAT_W-1:0]    dat_o,
	output logic                             ack_o
);

	logic [mpu_bus_pkg::DAT_W-1:0] mem [CARD_WORDS];
	logic                          req;

	assign req = cyc_i & stb_i & ~ack_o;   // one ack per access

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= req;
	end

	// ========================================
	// array with byte lane writes
	// ========================================

	always_ff @(posedge clk_i) begin
		if (req) begin
			if (we_i) begin
				for (int b = 0; b < mpu_bus_pkg::SEL_W; b++)
					if (sel_i[b])
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
			end
			dat_o <= mem[adr_i];   // old contents on a write cycle
		end
	end

endmodule

`default_nettype wire

// File: hw/mpu_periph.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_periph #(
	parameter int CARD_WORDS = 512,   // memory depth and decode size
	parameter int N_EXT_IRQ  = 28     // lines on controller sources 1 and up
) (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	input  wire                           cyc_i,
	input  wire                           stb_i,
	input  wire                           we_i,
	input  wire  [mpu_bus_pkg::SEL_W-1:0] sel_i,
	input  wire  [mpu_bus_pkg::ADR_W-1:0] adr_i,
	input  wire  [mpu_bus_pkg::DAT_W-1:0] dat_i,
	input  wire  [N_EXT_IRQ-1:0]          irq_lines_i,
	output logic [mpu_bus_pkg::DAT_W-1:0] dat_o,
	output logic                          ack_o,
	output logic                          err_o,
	output logic [2:0]                    irq_o,
	output logic [6:0]                    cause_o,
	output logic [2:0]                    pit_out_o
);

	localparam int CARD_AW = $clog2(CARD_WORDS);
	localparam int ADR_MSB = mpu_bus_pkg::ADR_W - 1;

	mpu_bus_pkg::region_e          region;
	logic                          pit_cyc, pic_cyc, card_cyc;
	logic                          pit_ack, pic_ack, card_ack;
	logic [mpu_bus_pkg::DAT_W-1:0] pit_dat, pic_dat, card_dat;
	logic [31:0]                   pic_src;

	// ========================================
	// address decode
	// ========================================

	always_comb begin
		region = mpu_bus_pkg::REG_NONE;
		if (adr_i[ADR_MSB:8] == mpu_bus_pkg::PIT_BASE[ADR_MSB:8])
			region = mpu_bus_pkg::REG_PIT;
		else if (adr_i[ADR_MSB:8] == mpu_bus_pkg::PIC_BASE[ADR_MSB:8])
			region = mpu_bus_pkg::REG_PIC;
		else if (adr_i[ADR_MSB:CARD_AW+2] == mpu_bus_pkg::CARD_BASE[ADR_MSB:CARD_AW+2])
			region = mpu_bus_pkg::REG_CARD;
	end

	// only the selected slave sees cyc
	assign pit_cyc  = cyc_i & (region == mpu_bus_pkg::REG_PIT);
	assign pic_cyc  = cyc_i & (region == mpu_bus_pkg::REG_PIC);
	assign card_cyc = cyc_i & (region == mpu_bus_pkg::REG_CARD);

	// timer channels 0,1,2 land on sources 31,30,29, source 0 stays idle
	assign pic_src = {pit_out_o[0], pit_out_o[1], pit_out_o[2], 28'(irq_lines_i), 1'b0};

	mpu_pit i_pit (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.cyc_i(pit_cyc), .stb_i(stb_i), .we_i(we_i), .sel_i(sel_i),
		.adr_i(adr_i[5:2]), .dat_i(dat_i), .dat_o(pit_dat), .ack_o(pit_ack),
		.out_o(pit_out_o)
	);

	mpu_pic i_pic (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.cyc_i(pic_cyc), .stb_i(stb_i), .we_i(we_i),
		.adr_i(adr_i[4:2]), .dat_i(dat_i), .src_i(pic_src),
		.dat_o(pic_dat), .ack_o(pic_ack), .irq_o(irq_o), .cause_o(cause_o)
	);

	mpu_card_mem #(.CARD_WORDS(CARD_WORDS)) i_card (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.cyc_i(card_cyc), .stb_i(stb_i), .we_i(we_i), .sel_i(sel_i),
		.adr_i(adr_i[CARD_AW+1:2]), .dat_i(dat_i), .dat_o(card_dat), .ack_o(card_ack)
	);

	// ========================================
	// response merge
	// ========================================

	// unmapped access, answered here with the same one clock latency
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			err_o <= 1'b0;
		else
			err_o <= cyc_i & stb_i & (region == mpu_bus_pkg::REG_NONE) & ~err_o;
	end

	assign ack_o = card_ack | pic_ack | pit_ack;

	always_comb begin
		if (card_ack)      dat_o = card_dat;   // fixed order card, pic, pit
		else if (pic_ack)  dat_o = pic_dat;
		else if (pit_ack)  dat_o = pit_dat;
		else               dat_o = '0;
	end

endmodule

`default_nettype wire

// File: bench/mpu_periph_properties.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_periph_properties (
	input wire       clk_i,
	input wire       rst_n_i,
	input wire       cyc_i,
	input wire       stb_i,
	input wire       ack_o,
	input wire       err_o,
	input wire [2:0] irq_o,
	input wire [6:0] cause_o
);

	int fail_cnt = 0;   // failed assertions so far, read by the testbench

	// ========================================
	// bus response rules
	// ========================================

	a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(ack_o && err_o))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("ack_o and err_o high in the same cycle");
		end

	// a response needs a strobe on the edge before
	a_resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ack_o || err_o) |-> $past(cyc_i && stb_i))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("response without a request");
		end

	a_resp_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ack_o || err_o) |=> !(ack_o || err_o))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("response held for two cycles");
		end

	// no level without a cause
	a_irq_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(cause_o == 7'd0) |-> (irq_o == 3'd0))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("irq_o set while cause_o is zero");
		end

endmodule

bind mpu_periph mpu_periph_properties i_props (
	.clk_i(clk_i), .rst_n_i(rst_n_i), .cyc_i(cyc_i), .stb_i(stb_i),
	.ack_o(ack_o), .err_o(err_o), .irq_o(irq_o), .cause_o(cause_o)
);

`default_nettype wire

// File: bench/tb_mpu_periph.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mpu_periph;

	localparam int          CARD_WORDS = 512;
	localparam int          N_EXT_IRQ  = 28;
	localparam int          CARD_AW    = $clog2(CARD_WORDS);
	localparam logic [31:0] CARD_BYTES = CARD_WORDS * 4;   // card region ends here
	localparam logic [31:0] SEED       = 32'h566e_0781;

	// ========================================
	// stimulus table
	// ========================================

	typedef enum logic [3:0] {
		OP_BUS,     // mapped access, expects ack
		OP_BAD,     // unmapped access, expects err
		OP_LINES,   // drive irq_lines_i with dat
		OP_PORT,    // irq_o == dat, cause_o == exp once registered
		OP_WAIT,    // wait for cause_o == exp, then irq_o == dat
		OP_TICK,    // wait for pulse count of channel adr[1:0] >= exp
		OP_PULSE,   // pulse count of channel adr[1:0] == exp
		OP_CAUSE    // bus read of cause equals the port
	} op_e;

	typedef struct packed {
		op_e         op;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp;
	} step_t;

	localparam int N_STEPS = 53;

	localparam step_t STEPS [N_STEPS] = '{
		// card memory, write data comes from the xorshift stream
		'{OP_BUS,   1'b1, 4'hF, 32'h0000_0000, 32'h0, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'h0000_0004, 32'h0, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'h0000_07FC, 32'h0, 32'h0},   // last word
		'{OP_BUS,   1'b1, 4'hF, 32'h0000_0010, 32'h0, 32'h0},
		'{OP_BUS,   1'b1, 4'h3, 32'h0000_0000, 32'h0, 32'h0},   // low half only
		'{OP_BUS,   1'b1, 4'hA, 32'h0000_0004, 32'h0, 32'h0},   // bytes 1 and 3
		'{OP_BUS,   1'b1, 4'h4, 32'h0000_0010, 32'h0, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'h0000_0000, 32'h0, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'h0000_0004, 32'h0, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'h0000_07FC, 32'h0, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'h0000_0010, 32'h0, 32'h0},
		// unmapped holes
		'{OP_BAD,   1'b0, 4'hF, 32'h0000_0800, 32'h0, 32'h0},   // just past the card
		'{OP_BAD,   1'b1, 4'hF, 32'hFFDC_1200, 32'h1234_5678, 32'h0},
		'{OP_BAD,   1'b0, 4'hF, 32'h8000_0000, 32'h0, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_1130, 32'h0, 32'h0},   // channel 3 reads 0
		// level sources 5, 12, 20 enabled
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F10, 32'h3, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F04, 32'h0010_1020, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_0F04, 32'h0, 32'h0010_1020},
		'{OP_LINES, 1'b0, 4'h0, 32'h0, 32'h0000_0810, 32'h0},   // sources 5, 12
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h3, 32'd12},
		'{OP_LINES, 1'b0, 4'h0, 32'h0, 32'h0100_0810, 32'h0},   // 25 is masked
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h3, 32'd12},
		'{OP_LINES, 1'b0, 4'h0, 32'h0, 32'h0108_0810, 32'h0},   // add 20
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h3, 32'd20},
		'{OP_LINES, 1'b0, 4'h0, 32'h0, 32'h0, 32'h0},
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h0, 32'd0},
		// channel 0 one-shot
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1100, 32'd20, 32'h0},
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_1100, 32'h0, 32'd20},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1108, 32'h1, 32'h0},
		'{OP_TICK,  1'b0, 4'h0, 32'h0, 32'h0, 32'd1},
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_1104, 32'h0, 32'h0},   // count at zero
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_1108, 32'h0, 32'h0},   // enable dropped
		'{OP_PULSE, 1'b0, 4'h0, 32'h0, 32'h0, 32'd1},
		// channel 1 one-shot into edge source 30
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F08, 32'h4000_0000, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F04, 32'h4000_0000, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F10, 32'h6, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1110, 32'd10, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1118, 32'h1, 32'h0},
		'{OP_WAIT,  1'b0, 4'h0, 32'h0, 32'h6, 32'd30},
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h6, 32'd30},           // latch holds
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_0F00, 32'h0, 32'd30},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F0C, 32'd30, 32'h0},
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h0, 32'd0},
		// channel 2 periodic into edge source 29
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F08, 32'h2000_0000, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F04, 32'h2000_0000, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1120, 32'd12, 32'h0},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1128, 32'h3, 32'h0},   // enable, periodic
		'{OP_TICK,  1'b0, 4'h0, 32'h2, 32'h0, 32'd3},
		'{OP_CAUSE, 1'b0, 4'hF, 32'hFFDC_0F00, 32'h0, 32'd29},
		'{OP_BUS,   1'b0, 4'hF, 32'hFFDC_1128, 32'h0, 32'h3},
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_1128, 32'h0, 32'h0},   // stop it
		'{OP_BUS,   1'b1, 4'hF, 32'hFFDC_0F0C, 32'd29, 32'h0},
		'{OP_PORT,  1'b0, 4'h0, 32'h0, 32'h0, 32'd0}
	};

	// ========================================
	// DUT and clock
	// ========================================

	logic                 clk_i, rst_n_i, cyc_i, stb_i, we_i;
	logic [3:0]           sel_i;
	logic [31:0]          adr_i, dat_i, dat_o;
	logic [N_EXT_IRQ-1:0] irq_lines_i;
	logic                 ack_o, err_o;
	logic [2:0]           irq_o, pit_out_o;
	logic [6:0]           cause_o;

	logic [31:0] model [CARD_WORDS];   // expected card contents
	logic [31:0] rng;
	logic [6:0]  cause_seen;           // cause_o at the ack of the last access
	int          pulse_cnt [3] = '{0, 0, 0};
	int          errors;
	int          cycles;

	mpu_periph #(.CARD_WORDS(CARD_WORDS), .N_EXT_IRQ(N_EXT_IRQ)) i_dut (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i), .irq_lines_i(irq_lines_i),
		.dat_o(dat_o), .ack_o(ack_o), .err_o(err_o), .irq_o(irq_o),
		.cause_o(cause_o), .pit_out_o(pit_out_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;   // 20 ns period
	end

	// each timer pulse is high for exactly one negedge
	always @(negedge clk_i) begin
		if (rst_n_i === 1'b1)
			for (int i = 0; i < 3; i++)
				if (pit_out_o[i] === 1'b1)
					pulse_cnt[i] = pulse_cnt[i] + 1;
	end

	// ========================================
	// helpers
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int timeout_limit();
		int top_load;
		top_load = 0;
		for (int i = 0; i < N_STEPS; i++)
			if (STEPS[i].op == OP_BUS && STEPS[i].we &&
			    STEPS[i].adr[31:8] == 24'hFFDC11 && STEPS[i].adr[3:2] == 2'd0 &&
			    int'(STEPS[i].dat) > top_load)
				top_load = int'(STEPS[i].dat);   // timer reload values
		return N_STEPS * 4 + top_load + 50;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// one Wishbone classic access, inputs held until ack or err
	task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
	                          input logic [31:0] wdat, output logic [31:0] rdat,
	                          output logic got_ack, output logic got_err);
		@(posedge clk_i);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i  <= we;
		sel_i <= sel;
		adr_i <= adr;
		dat_i <= wdat;
		do
			@(negedge clk_i);
		while (!(ack_o || err_o));
		rdat       = dat_o;
		got_ack    = ack_o;
		got_err    = err_o;
		cause_seen = cause_o;
		@(posedge clk_i);
		cyc_i <= 1'b0;   // one idle cycle between accesses
		stb_i <= 1'b0;
		we_i  <= 1'b0;
	endtask

	task automatic run_step(input step_t s);
		logic [31:0] wdat, rdat, want;
		logic        got_ack, got_err;
		int          ch;
		ch   = int'(s.adr[1:0]);
		wdat = s.dat;
		want = s.exp;
		case (s.op)
		OP_BUS, OP_CAUSE: begin
			if (s.adr < CARD_BYTES) begin
				if (s.we) begin
					rng  = xorshift(rng);
					wdat = rng;
					for (int b = 0; b < 4; b++)
						if (s.sel[b])
							model[s.adr[CARD_AW+1:2]][8*b +: 8] = wdat[8*b +: 8];
				end
				want = model[s.adr[CARD_AW+1:2]];
			end
			bus_access(s.we, s.sel, s.adr, wdat, rdat, got_ack, got_err);
			check_value("ack_o", got_ack, 1'b1);
			check_value("err_o", got_err, 1'b0);
			if (!s.we)
				check_value("dat_o", rdat, want);
			if (s.op == OP_CAUSE)
				check_value("cause_o", {25'd0, cause_seen}, rdat);   // port vs register
		end
		OP_BAD: begin
			bus_access(s.we, s.sel, s.adr, wdat, rdat, got_ack, got_err);
			check_value("err_o", got_err, 1'b1);
			check_value("ack_o", got_ack, 1'b0);
		end
		OP_LINES: begin
			@(posedge clk_i);
			irq_lines_i <= s.dat[N_EXT_IRQ-1:0];
		end
		OP_PORT: begin
			repeat (2) @(posedge clk_i);   // registered one clock after the change
			@(negedge clk_i);
			check_value("irq_o", irq_o, s.dat);
			check_value("cause_o", cause_o, s.exp);
		end
		OP_WAIT: begin
			do
				@(negedge clk_i);
			while (cause_o !== s.exp[6:0]);
			check_value("irq_o", irq_o, s.dat);
		end
		OP_TICK: begin
			do
				@(negedge clk_i);
			while (pulse_cnt[ch] < int'(s.exp));
		end
		OP_PULSE: check_value("pit_out_o pulses", pulse_cnt[ch], s.exp);
		default: ;
		endcase
	endtask

	// ========================================
	// main sequence and watchdog
	// ========================================

	initial begin
		int limit;
		limit  = timeout_limit();
		cycles = 0;
		wait (rst_n_i === 1'b1);
		while (cycles < limit) begin
			@(posedge clk_i);
			cycles = cycles + 1;
		end
		$display("timeout: the DUT did not respond within %0d cycles", limit);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped by the watchdog");
	end

	initial begin
		rst_n_i     <= 1'b0;
		cyc_i       <= 1'b0;
		stb_i       <= 1'b0;
		we_i        <= 1'b0;
		sel_i       <= '0;
		adr_i       <= '0;
		dat_i       <= '0;
		irq_lines_i <= '0;
		rng    = SEED;
		repeat (8) @(posedge clk_i);   // reset held for 8 cycles
		@(negedge clk_i);
		check_value("ack_o", ack_o, 1'b0);
		check_value("err_o", err_o, 1'b0);
		check_value("irq_o", irq_o, 3'd0);
		check_value("cause_o", cause_o, 7'd0);
		check_value("pit_out_o", pit_out_o, 3'd0);
		@(posedge clk_i);
		rst_n_i <= 1'b1;
		for (int i = 0; i < N_STEPS; i++)
			run_step(STEPS[i]);
		repeat (2) @(posedge clk_i);
		errors = i_dut.i_props.fail_cnt;   // failures of the bound assertions
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: mpu_periph.f
hw/mpu_bus_pkg.sv
hw/mpu_reg_pkg.sv
hw/mpu_pit.sv
hw/mpu_pic.sv
hw/mpu_card_mem.sv
hw/mpu_periph.sv
bench/mpu_periph_properties.sv
bench/tb_mpu_periph.sv

// File: Bender.yml
package:
  name: mpu_periph

dependencies: {}

sources:
  # packages first, then the leaf slaves and the top level
  - files:
      - hw/mpu_bus_pkg.sv
      - hw/mpu_reg_pkg.sv
      - hw/mpu_pit.sv
      - hw/mpu_pic.sv
      - hw/mpu_card_mem.sv
      - hw/mpu_periph.sv

  # simulation only
  - target: test
    files:
      - bench/mpu_periph_properties.sv
      - bench/tb_mpu_periph.sv

# top modules: tb_mpu_periph for simulation, mpu_periph for synthesis
